//--- amo_mem_settings.svh
`ifndef AMO_MEM_SETTINGS_SVH
`define AMO_MEM_SETTINGS_SVH

// Width of the byte address on every port
`define AMO_ADDR_WIDTH 32

// Data word width, one bank word per access
`define AMO_DATA_WIDTH 32

// Number of words in the single SRAM bank
`define AMO_BANK_WORDS 256

// Peer requesters sharing the bank
`define AMO_NUM_PORTS 2

`endif

//--- amo_mem_bus_pkg.sv
`include "amo_mem_settings.svh"

package amo_mem_bus_pkg;

    // Byte address as seen by the requesters
    typedef logic [`AMO_ADDR_WIDTH-1:0] addr_t;

    // One bank word
    typedef logic [`AMO_DATA_WIDTH-1:0] data_t;

    // One enable bit per data byte
    typedef logic [`AMO_DATA_WIDTH/8-1:0] be_t;

    // Index of a requesting port, at least one bit wide
    typedef logic [$clog2(`AMO_NUM_PORTS)-1:0] port_idx_t;

endpackage

//--- amo_mem_op_pkg.sv
package amo_mem_op_pkg;

    // Atomic operation carried next to each request
    typedef enum logic [3:0] {
        AmoNone = 4'h0,
        AmoSwap = 4'h1,
        AmoAdd  = 4'h2,
        AmoAnd  = 4'h3,
        AmoOr   = 4'h4,
        AmoXor  = 4'h5,
        AmoMax  = 4'h6,
        AmoMaxu = 4'h7,
        AmoMin  = 4'h8,
        AmoMinu = 4'h9
    } amo_op_e;

    // True for any read-modify-write request
    function automatic logic is_amo(amo_op_e op);
        return op != AmoNone;
    endfunction

endpackage

//--- bank_arbiter.sv
`timescale 1ns/1ps
`include "amo_mem_settings.svh"

module bank_arbiter (
    input  logic                                         clk_i,
    input  logic                                         rst_ni,
    // Requester side, one entry per port
    input  logic [`AMO_NUM_PORTS-1:0]                    req_i,
    output logic [`AMO_NUM_PORTS-1:0]                    gnt_o,
    input  amo_mem_op_pkg::amo_op_e [`AMO_NUM_PORTS-1:0] amo_i,
    input  logic [`AMO_NUM_PORTS-1:0]                    wen_i,
    input  amo_mem_bus_pkg::addr_t [`AMO_NUM_PORTS-1:0]  addr_i,
    input  amo_mem_bus_pkg::data_t [`AMO_NUM_PORTS-1:0]  wdata_i,
    input  amo_mem_bus_pkg::be_t [`AMO_NUM_PORTS-1:0]    be_i,
    output amo_mem_bus_pkg::data_t [`AMO_NUM_PORTS-1:0]  rdata_o,
    // Bank side
    output logic                                         bank_req_o,
    input  logic                                         bank_gnt_i,
    output amo_mem_bus_pkg::addr_t                       bank_addr_o,
    output amo_mem_op_pkg::amo_op_e                      bank_amo_o,
    output logic                                         bank_wen_o,
    output amo_mem_bus_pkg::data_t                       bank_wdata_o,
    output amo_mem_bus_pkg::be_t                         bank_be_o,
    input  amo_mem_bus_pkg::data_t                       bank_rdata_i
);

    amo_mem_bus_pkg::port_idx_t rr_q;
    amo_mem_bus_pkg::port_idx_t gnt_idx_q;
    amo_mem_bus_pkg::port_idx_t sel_idx;
    logic                       sel_valid;

    // ------------------------------------------------------------
    // Round-robin choice starting at the priority pointer
    // ------------------------------------------------------------
    always_comb begin
        sel_valid = 1'b0;
        sel_idx   = rr_q;
        for (int unsigned i = 0; i < `AMO_NUM_PORTS; i++) begin
            if (!sel_valid && req_i[(rr_q + i) % `AMO_NUM_PORTS]) begin
                sel_valid = 1'b1;
                sel_idx   = amo_mem_bus_pkg::port_idx_t'((rr_q + i) % `AMO_NUM_PORTS);
            end
        end
    end

    // Selected port's fields go to the bank
    assign bank_req_o   = sel_valid;
    assign bank_addr_o  = addr_i[sel_idx];
    assign bank_amo_o   = amo_i[sel_idx];
    assign bank_wen_o   = wen_i[sel_idx];
    assign bank_wdata_o = wdata_i[sel_idx];
    assign bank_be_o    = be_i[sel_idx];

    // Bank grant reaches only the chosen port
    always_comb begin
        gnt_o          = '0;
        gnt_o[sel_idx] = sel_valid & bank_gnt_i;
    end

    // Read data belongs to whoever was granted last cycle
    always_comb begin
        rdata_o            = '0;
        rdata_o[gnt_idx_q] = bank_rdata_i;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rr_q      <= '0;
            gnt_idx_q <= '0;
        end else if (sel_valid && bank_gnt_i) begin
            // Move priority past the winner
            rr_q      <= amo_mem_bus_pkg::port_idx_t'((sel_idx + 1) % `AMO_NUM_PORTS);
            gnt_idx_q <= sel_idx;
        end
    end

    // At most one port granted, and only one that is asking
    a_gnt_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0(gnt_o) && ((gnt_o & ~req_i) == '0))
        else $error("bank_arbiter: grant is not one-hot or has no matching request");

endmodule

//--- amo_shim.sv
`timescale 1ns/1ps
`include "amo_mem_settings.svh"

module amo_shim (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    // From the arbiter
    input  logic                    in_req_i,
    output logic                    in_gnt_o,
    input  amo_mem_bus_pkg::addr_t  in_addr_i,
    input  amo_mem_op_pkg::amo_op_e in_amo_i,
    input  logic                    in_wen_i,
    input  amo_mem_bus_pkg::data_t  in_wdata_i,
    input  amo_mem_bus_pkg::be_t    in_be_i,
    output amo_mem_bus_pkg::data_t  in_rdata_o,
    // To the SRAM
    output logic                    out_req_o,
    output amo_mem_bus_pkg::addr_t  out_addr_o,
    output logic                    out_wen_o,
    output amo_mem_bus_pkg::data_t  out_wdata_o,
    output amo_mem_bus_pkg::be_t    out_be_o,
    input  amo_mem_bus_pkg::data_t  out_rdata_i
);

    typedef enum logic {
        Idle,
        DoAMO
    } state_e;

    state_e state_q;
    state_e state_d;
    logic   load_amo;

    // Captured when an atomic is accepted
    amo_mem_op_pkg::amo_op_e amo_op_q;
    amo_mem_bus_pkg::addr_t  addr_q;
    amo_mem_bus_pkg::be_t    be_q;
    amo_mem_bus_pkg::data_t  operand_b_q;

    amo_mem_bus_pkg::data_t  amo_result;
    logic                    cmp_signed;
    logic                    do_sub;
    logic [`AMO_DATA_WIDTH:0] adder_a;
    logic [`AMO_DATA_WIDTH:0] adder_b;
    logic [`AMO_DATA_WIDTH:0] adder_sum;
    logic                    a_lt_b;

    // ------------------------------------------------------------
    // Request path and sequencing
    // ------------------------------------------------------------
    always_comb begin
        out_req_o   = in_req_i;
        in_gnt_o    = in_req_i;
        out_addr_o  = in_addr_i;
        out_wen_o   = in_wen_i;
        out_wdata_o = in_wdata_i;
        out_be_o    = in_be_i;
        load_amo    = 1'b0;
        state_d     = Idle;

        case (state_q)
            Idle: begin
                if (in_req_i && amo_mem_op_pkg::is_amo(in_amo_i)) begin
                    // First half of an atomic reads the old word
                    load_amo  = 1'b1;
                    out_wen_o = 1'b0;
                    state_d   = DoAMO;
                end
            end
            DoAMO: begin
                // Bank is ours this cycle, commit the result
                in_gnt_o    = 1'b0;
                out_req_o   = 1'b1;
                out_addr_o  = addr_q;
                out_wen_o   = |be_q;
                out_wdata_o = amo_result;
                out_be_o    = be_q;
            end
            default: begin
                in_gnt_o  = 1'b0;
                out_req_o = 1'b0;
            end
        endcase
    end

    // Old word comes back from the read in either state
    assign in_rdata_o = out_rdata_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= Idle;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load_amo) begin
            amo_op_q    <= in_amo_i;
            addr_q      <= in_addr_i;
            be_q        <= in_be_i;
            operand_b_q <= in_wdata_i;
        end
    end

    // ------------------------------------------------------------
    // AMO ALU with one shared adder
    // ------------------------------------------------------------
    always_comb begin
        cmp_signed = (amo_op_q == amo_mem_op_pkg::AmoMax)
                  || (amo_op_q == amo_mem_op_pkg::AmoMin);
        do_sub     = cmp_signed
                  || (amo_op_q == amo_mem_op_pkg::AmoMaxu)
                  || (amo_op_q == amo_mem_op_pkg::AmoMinu);
        // Extra top bit holds the sign or a zero
        adder_a = {cmp_signed & out_rdata_i[`AMO_DATA_WIDTH-1], out_rdata_i};
        adder_b = {cmp_signed & operand_b_q[`AMO_DATA_WIDTH-1], operand_b_q};
        if (do_sub) begin
            adder_b = ~adder_b;
        end
    end

    assign adder_sum = adder_a + adder_b + {{`AMO_DATA_WIDTH{1'b0}}, do_sub};
    // Sign of old word minus operand
    assign a_lt_b    = adder_sum[`AMO_DATA_WIDTH];

    always_comb begin
        case (amo_op_q)
            amo_mem_op_pkg::AmoSwap: amo_result = operand_b_q;
            amo_mem_op_pkg::AmoAdd:  amo_result = adder_sum[`AMO_DATA_WIDTH-1:0];
            amo_mem_op_pkg::AmoAnd:  amo_result = out_rdata_i & operand_b_q;
            amo_mem_op_pkg::AmoOr:   amo_result = out_rdata_i | operand_b_q;
            amo_mem_op_pkg::AmoXor:  amo_result = out_rdata_i ^ operand_b_q;
            amo_mem_op_pkg::AmoMax,
            amo_mem_op_pkg::AmoMaxu: amo_result = a_lt_b ? operand_b_q : out_rdata_i;
            amo_mem_op_pkg::AmoMin,
            amo_mem_op_pkg::AmoMinu: amo_result = a_lt_b ? out_rdata_i : operand_b_q;
            default:                 amo_result = out_rdata_i;
        endcase
    end

    // Accepted atomic blocks the next grant and writes back
    a_amo_holds_bank: assert property (@(posedge clk_i) disable iff (!rst_ni)
        load_amo |=> (state_q == DoAMO) && !in_gnt_o && out_req_o)
        else $error("amo_shim: atomic did not claim the bank in the following cycle");

    a_amo_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (state_q == DoAMO) |=> (state_q == Idle))
        else $error("amo_shim: write-back phase lasted more than one cycle");

endmodule

//--- sram_bank.sv
`timescale 1ns/1ps
`include "amo_mem_settings.svh"

module sram_bank (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   req_i,
    input  amo_mem_bus_pkg::addr_t addr_i,
    input  logic                   wen_i,
    input  amo_mem_bus_pkg::data_t wdata_i,
    input  amo_mem_bus_pkg::be_t   be_i,
    output amo_mem_bus_pkg::data_t rdata_o
);

    localparam int unsigned off_w = $clog2(`AMO_DATA_WIDTH / 8);
    localparam int unsigned idx_w = $clog2(`AMO_BANK_WORDS);

    logic [idx_w-1:0]       word_idx;
    amo_mem_bus_pkg::data_t mem_q [`AMO_BANK_WORDS];
    amo_mem_bus_pkg::data_t rdata_q;

    // Drop the byte offset, keep the word index
    assign word_idx = addr_i[off_w +: idx_w];

    always_ff @(posedge clk_i) begin
        if (req_i && wen_i) begin
            for (int unsigned b = 0; b < `AMO_DATA_WIDTH / 8; b++) begin
                if (be_i[b]) begin
                    mem_q[word_idx][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

    // Read returns the word as it was before any write this cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rdata_q <= '0;
        end else if (req_i) begin
            rdata_q <= mem_q[word_idx];
        end
    end

    assign rdata_o = rdata_q;

endmodule

//--- amo_mem_top.sv
`timescale 1ns/1ps
`include "amo_mem_settings.svh"

module amo_mem_top (
    input  logic                                         clk_i,
    input  logic                                         rst_ni,
    input  logic [`AMO_NUM_PORTS-1:0]                    port_req_i,
    output logic [`AMO_NUM_PORTS-1:0]                    port_gnt_o,
    input  amo_mem_bus_pkg::addr_t [`AMO_NUM_PORTS-1:0]  port_addr_i,
    input  amo_mem_op_pkg::amo_op_e [`AMO_NUM_PORTS-1:0] port_amo_i,
    input  logic [`AMO_NUM_PORTS-1:0]                    port_wen_i,
    input  amo_mem_bus_pkg::data_t [`AMO_NUM_PORTS-1:0]  port_wdata_i,
    input  amo_mem_bus_pkg::be_t [`AMO_NUM_PORTS-1:0]    port_be_i,
    output amo_mem_bus_pkg::data_t [`AMO_NUM_PORTS-1:0]  port_rdata_o
);

    // Arbiter to shim
    logic                    bank_req;
    logic                    bank_gnt;
    amo_mem_bus_pkg::addr_t  bank_addr;
    amo_mem_op_pkg::amo_op_e bank_amo;
    logic                    bank_wen;
    amo_mem_bus_pkg::data_t  bank_wdata;
    amo_mem_bus_pkg::be_t    bank_be;
    amo_mem_bus_pkg::data_t  bank_rdata;

    // Shim to SRAM
    logic                    sram_req;
    amo_mem_bus_pkg::addr_t  sram_addr;
    logic                    sram_wen;
    amo_mem_bus_pkg::data_t  sram_wdata;
    amo_mem_bus_pkg::be_t    sram_be;
    amo_mem_bus_pkg::data_t  sram_rdata;

    bank_arbiter bank_arbiter_i (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .req_i        (port_req_i),
        .gnt_o        (port_gnt_o),
        .amo_i        (port_amo_i),
        .wen_i        (port_wen_i),
        .addr_i       (port_addr_i),
        .wdata_i      (port_wdata_i),
        .be_i         (port_be_i),
        .rdata_o      (port_rdata_o),
        .bank_req_o   (bank_req),
        .bank_gnt_i   (bank_gnt),
        .bank_addr_o  (bank_addr),
        .bank_amo_o   (bank_amo),
        .bank_wen_o   (bank_wen),
        .bank_wdata_o (bank_wdata),
        .bank_be_o    (bank_be),
        .bank_rdata_i (bank_rdata)
    );

    amo_shim amo_shim_i (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .in_req_i    (bank_req),
        .in_gnt_o    (bank_gnt),
        .in_addr_i   (bank_addr),
        .in_amo_i    (bank_amo),
        .in_wen_i    (bank_wen),
        .in_wdata_i  (bank_wdata),
        .in_be_i     (bank_be),
        .in_rdata_o  (bank_rdata),
        .out_req_o   (sram_req),
        .out_addr_o  (sram_addr),
        .out_wen_o   (sram_wen),
        .out_wdata_o (sram_wdata),
        .out_be_o    (sram_be),
        .out_rdata_i (sram_rdata)
    );

    sram_bank sram_bank_i (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .req_i   (sram_req),
        .addr_i  (sram_addr),
        .wen_i   (sram_wen),
        .wdata_i (sram_wdata),
        .be_i    (sram_be),
        .rdata_o (sram_rdata)
    );

endmodule

//--- amo_mem_checker.sv
`timescale 1ns/1ps
`include "amo_mem_settings.svh"

module amo_mem_checker #(
    parameter int NAME_W = 16
) (
    input  logic                                         clk_i,
    input  logic                                         rst_ni,
    input  logic [`AMO_NUM_PORTS-1:0]                    req_i,
    input  logic [`AMO_NUM_PORTS-1:0]                    gnt_i,
    input  amo_mem_bus_pkg::addr_t [`AMO_NUM_PORTS-1:0]  addr_i,
    input  amo_mem_op_pkg::amo_op_e [`AMO_NUM_PORTS-1:0] amo_i,
    input  logic [`AMO_NUM_PORTS-1:0]                    wen_i,
    input  amo_mem_bus_pkg::data_t [`AMO_NUM_PORTS-1:0]  wdata_i,
    input  amo_mem_bus_pkg::be_t [`AMO_NUM_PORTS-1:0]    be_i,
    input  amo_mem_bus_pkg::data_t [`AMO_NUM_PORTS-1:0]  rdata_i,
    input  logic [`AMO_NUM_PORTS-1:0][NAME_W*8-1:0]      name_i,
    output int                                           errors_o,
    output int                                           checks_o
);

    // Reference copy of the bank, one entry per word
    amo_mem_bus_pkg::data_t model [`AMO_BANK_WORDS];

    // Read waiting for its data in the next cycle
    logic                   pend_valid;
    int                     pend_port;
    amo_mem_bus_pkg::data_t pend_exp;
    logic [NAME_W*8-1:0]    pend_name;

    logic                   amo_last;
    int                     waits [`AMO_NUM_PORTS];

    // New memory word for an atomic, from the old word and the operand
    function automatic amo_mem_bus_pkg::data_t apply_amo(input amo_mem_op_pkg::amo_op_e op,
                                                         input amo_mem_bus_pkg::data_t old,
                                                         input amo_mem_bus_pkg::data_t opnd);
        case (op)
            amo_mem_op_pkg::AmoSwap: return opnd;
            amo_mem_op_pkg::AmoAdd:  return old + opnd;
            amo_mem_op_pkg::AmoAnd:  return old & opnd;
            amo_mem_op_pkg::AmoOr:   return old | opnd;
            amo_mem_op_pkg::AmoXor:  return old ^ opnd;
            amo_mem_op_pkg::AmoMax:  return ($signed(old) > $signed(opnd)) ? old : opnd;
            amo_mem_op_pkg::AmoMaxu: return (old > opnd) ? old : opnd;
            amo_mem_op_pkg::AmoMin:  return ($signed(old) < $signed(opnd)) ? old : opnd;
            amo_mem_op_pkg::AmoMinu: return (old < opnd) ? old : opnd;
            default:                 return old;
        endcase
    endfunction

    task automatic write_masked(input int idx, input amo_mem_bus_pkg::data_t data,
                                input amo_mem_bus_pkg::be_t be);
        for (int b = 0; b < `AMO_DATA_WIDTH / 8; b++) begin
            if (be[b]) begin
                model[idx][8*b +: 8] = data[8*b +: 8];
            end
        end
    endtask

    initial begin
        for (int i = 0; i < `AMO_BANK_WORDS; i++) begin
            model[i] = '0;
        end
        for (int p = 0; p < `AMO_NUM_PORTS; p++) begin
            waits[p] = 0;
        end
        errors_o   = 0;
        checks_o   = 0;
        pend_valid = 1'b0;
        amo_last   = 1'b0;
    end

    // ------------------------------------------------------------
    // Sample on the falling edge, between driver updates
    // ------------------------------------------------------------
    always @(negedge clk_i) begin : check_cycle
        int                     idx;
        amo_mem_bus_pkg::data_t old;
        if (!rst_ni) begin
            pend_valid = 1'b0;
            amo_last   = 1'b0;
        end else begin
            // Data for last cycle's read
            if (pend_valid) begin
                checks_o++;
                if (rdata_i[pend_port] !== pend_exp) begin
                    errors_o++;
                    $display("[FAIL] %0s: expected 32'h%08h, actual 32'h%08h",
                             pend_name, pend_exp, rdata_i[pend_port]);
                end
            end
            pend_valid = 1'b0;
            if (!$onehot0(gnt_i)) begin
                errors_o++;
                $display("More than one port was granted in the same cycle at %0t", $time);
            end
            if (amo_last && (gnt_i != '0)) begin
                errors_o++;
                $display("A port was granted in the cycle after an atomic at %0t", $time);
            end
            amo_last = 1'b0;
            for (int p = 0; p < `AMO_NUM_PORTS; p++) begin
                if (gnt_i[p]) begin
                    idx = int'((addr_i[p] >> 2) % `AMO_BANK_WORDS);
                    old = model[idx];
                    if (amo_i[p] != amo_mem_op_pkg::AmoNone) begin
                        write_masked(idx, apply_amo(amo_i[p], old, wdata_i[p]), be_i[p]);
                        amo_last = 1'b1;
                    end else if (wen_i[p]) begin
                        write_masked(idx, wdata_i[p], be_i[p]);
                    end
                    if (!wen_i[p] || (amo_i[p] != amo_mem_op_pkg::AmoNone)) begin
                        pend_valid = 1'b1;
                        pend_port  = p;
                        pend_exp   = old;
                        pend_name  = name_i[p];
                    end
                    waits[p] = 0;
                end else if (!req_i[p]) begin
                    waits[p] = 0;
                end else if (gnt_i != '0) begin
                    waits[p]++;
                    if (waits[p] > 2) begin
                        errors_o++;
                        $display("Port %0d waited for more than two grants to the other port", p);
                    end
                end
            end
        end
    end

endmodule

//--- tb_amo_mem.sv
`timescale 1ns/1ps
`include "amo_mem_settings.svh"

module tb_amo_mem;

    localparam int NAME_W      = 16;
    localparam int REQ_TIMEOUT = 50;
    localparam int NUM_PHASES  = 3;

    typedef struct packed {
        logic [NAME_W*8-1:0]     name;
        logic                    port;
        logic [1:0]              phase;
        amo_mem_op_pkg::amo_op_e op;
        logic                    store;
        amo_mem_bus_pkg::addr_t  addr;
        amo_mem_bus_pkg::data_t  wdata;
        amo_mem_bus_pkg::be_t    be;
    } entry_t;

    logic                                         clk_i;
    logic                                         rst_ni;
    logic [`AMO_NUM_PORTS-1:0]                    port_req;
    logic [`AMO_NUM_PORTS-1:0]                    port_gnt;
    amo_mem_bus_pkg::addr_t [`AMO_NUM_PORTS-1:0]  port_addr;
    amo_mem_op_pkg::amo_op_e [`AMO_NUM_PORTS-1:0] port_amo;
    logic [`AMO_NUM_PORTS-1:0]                    port_wen;
    amo_mem_bus_pkg::data_t [`AMO_NUM_PORTS-1:0]  port_wdata;
    amo_mem_bus_pkg::be_t [`AMO_NUM_PORTS-1:0]    port_be;
    amo_mem_bus_pkg::data_t [`AMO_NUM_PORTS-1:0]  port_rdata;
    logic [`AMO_NUM_PORTS-1:0][NAME_W*8-1:0]      port_name;

    entry_t stim_q[$];
    int     check_errors;
    int     check_count;
    int     driver_errors;

    initial clk_i = 1'b0;
    always #4 clk_i = ~clk_i;

    amo_mem_top amo_mem_top_i (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .port_req_i   (port_req),
        .port_gnt_o   (port_gnt),
        .port_addr_i  (port_addr),
        .port_amo_i   (port_amo),
        .port_wen_i   (port_wen),
        .port_wdata_i (port_wdata),
        .port_be_i    (port_be),
        .port_rdata_o (port_rdata)
    );

    amo_mem_checker #(.NAME_W(NAME_W)) amo_mem_checker_i (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .req_i    (port_req),
        .gnt_i    (port_gnt),
        .addr_i   (port_addr),
        .amo_i    (port_amo),
        .wen_i    (port_wen),
        .wdata_i  (port_wdata),
        .be_i     (port_be),
        .rdata_i  (port_rdata),
        .name_i   (port_name),
        .errors_o (check_errors),
        .checks_o (check_count)
    );

    task automatic add_entry(input logic [NAME_W*8-1:0] name, input int port, input int phase,
                             input amo_mem_op_pkg::amo_op_e op, input logic store,
                             input amo_mem_bus_pkg::addr_t addr,
                             input amo_mem_bus_pkg::data_t wdata,
                             input amo_mem_bus_pkg::be_t be);
        entry_t e;
        e.name  = name;
        e.port  = port[0];
        e.phase = phase[1:0];
        e.op    = op;
        e.store = store;
        e.addr  = addr;
        e.wdata = wdata;
        e.be    = be;
        stim_q.push_back(e);
    endtask

    // ------------------------------------------------------------
    // Stimulus table: phase 0 single accesses, 1 race, 2 streams
    // ------------------------------------------------------------
    task automatic load_table();
        add_entry("st_full", 0, 0, amo_mem_op_pkg::AmoNone, 1, 'h10, 'hdead_beef, 'hf);
        add_entry("ld_full", 0, 0, amo_mem_op_pkg::AmoNone, 0, 'h10, 'h0, 'hf);
        add_entry("st_byte", 0, 0, amo_mem_op_pkg::AmoNone, 1, 'h10, 'h1122_3344, 'h5);
        add_entry("ld_byte", 0, 0, amo_mem_op_pkg::AmoNone, 0, 'h10, 'h0, 'hf);
        add_entry("st_logic_init", 0, 0, amo_mem_op_pkg::AmoNone, 1, 'h20, 'h0f0f_1234, 'hf);
        add_entry("amo_swap", 0, 0, amo_mem_op_pkg::AmoSwap, 0, 'h20, 'ha5a5_a5a5, 'hf);
        add_entry("amo_add", 0, 0, amo_mem_op_pkg::AmoAdd, 0, 'h20, 'h0000_0101, 'hf);
        add_entry("amo_and", 0, 0, amo_mem_op_pkg::AmoAnd, 0, 'h20, 'hffff_00ff, 'hf);
        add_entry("amo_or", 0, 0, amo_mem_op_pkg::AmoOr, 0, 'h20, 'h000f_0000, 'hf);
        add_entry("amo_xor", 0, 0, amo_mem_op_pkg::AmoXor, 0, 'h20, 'h1234_5678, 'hf);
        add_entry("ld_logic", 0, 0, amo_mem_op_pkg::AmoNone, 0, 'h20, 'h0, 'hf);
        add_entry("st_cmp_init", 1, 0, amo_mem_op_pkg::AmoNone, 1, 'h30, 'h8000_0005, 'hf);
        add_entry("amo_max", 1, 0, amo_mem_op_pkg::AmoMax, 0, 'h30, 'h0000_0007, 'hf);
        add_entry("amo_maxu", 1, 0, amo_mem_op_pkg::AmoMaxu, 0, 'h30, 'h9000_0000, 'hf);
        add_entry("amo_min", 1, 0, amo_mem_op_pkg::AmoMin, 0, 'h30, 'h0000_0003, 'hf);
        add_entry("amo_minu", 1, 0, amo_mem_op_pkg::AmoMinu, 0, 'h30, 'h0000_0003, 'hf);
        add_entry("ld_cmp", 1, 0, amo_mem_op_pkg::AmoNone, 0, 'h30, 'h0, 'hf);
        add_entry("st_race_init", 1, 0, amo_mem_op_pkg::AmoNone, 1, 'h40, 'h0000_0064, 'hf);
        // Same address, same cycle
        add_entry("race_add_p0", 0, 1, amo_mem_op_pkg::AmoAdd, 0, 'h40, 'h0000_0010, 'hf);
        add_entry("race_add_p1", 1, 1, amo_mem_op_pkg::AmoAdd, 0, 'h40, 'h0000_0200, 'hf);
        add_entry("stream_ld_a", 0, 2, amo_mem_op_pkg::AmoNone, 0, 'h10, 'h0, 'hf);
        add_entry("stream_amo_a", 0, 2, amo_mem_op_pkg::AmoXor, 0, 'h30, 'h0000_ff00, 'hf);
        add_entry("stream_ld_b", 0, 2, amo_mem_op_pkg::AmoNone, 0, 'h30, 'h0, 'hf);
        add_entry("race_final", 1, 2, amo_mem_op_pkg::AmoNone, 0, 'h40, 'h0, 'hf);
        add_entry("stream_amo_b", 1, 2, amo_mem_op_pkg::AmoOr, 0, 'h20, 'h0000_0001, 'hf);
        add_entry("stream_ld_c", 1, 2, amo_mem_op_pkg::AmoNone, 0, 'h20, 'h0, 'hf);
    endtask

    // Present each entry of one port and phase, hold until granted
    task automatic drive_port(input int p, input int ph);
        int waited;
        int gap;
        foreach (stim_q[i]) begin
            if (stim_q[i].port == p && stim_q[i].phase == ph) begin
                port_name[p]  = stim_q[i].name;
                port_amo[p]   = stim_q[i].op;
                port_wen[p]   = stim_q[i].store;
                port_addr[p]  = stim_q[i].addr;
                port_wdata[p] = stim_q[i].wdata;
                port_be[p]    = stim_q[i].be;
                port_req[p]   = 1'b1;
                waited = 0;
                @(negedge clk_i);
                while (!port_gnt[p] && waited < REQ_TIMEOUT) begin
                    waited++;
                    @(negedge clk_i);
                end
                if (!port_gnt[p]) begin
                    driver_errors++;
                    $display("Port %0d: request %0s was not granted within %0d cycles",
                             p, stim_q[i].name, REQ_TIMEOUT);
                end
                @(posedge clk_i);
                #1;
                port_req[p] = 1'b0;
                // Later phases keep requests back to back
                if (ph == 0) begin
                    gap = $urandom_range(2, 0);
                    repeat (gap) begin
                        @(posedge clk_i);
                        #1;
                    end
                end
            end
        end
    endtask

    initial begin
        void'($urandom(32'h292e_eb98));
        rst_ni        = 1'b0;
        port_req      = '0;
        port_addr     = '0;
        port_wen      = '0;
        port_wdata    = '0;
        port_be       = '0;
        port_name     = '0;
        driver_errors = 0;
        for (int p = 0; p < `AMO_NUM_PORTS; p++) begin
            port_amo[p] = amo_mem_op_pkg::AmoNone;
        end
        load_table();
        repeat (3) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        @(posedge clk_i);
        #1;
        for (int ph = 0; ph < NUM_PHASES; ph++) begin
            fork
                drive_port(0, ph);
                drive_port(1, ph);
            join
        end
        // Let the last read data reach the checker
        repeat (4) @(posedge clk_i);
        $display("Summary: %0d read checks, %0d checker errors, %0d request timeouts",
                 check_count, check_errors, driver_errors);
        if (check_errors == 0 && driver_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- amo_mem.f
+incdir+.
amo_mem_bus_pkg.sv
amo_mem_op_pkg.sv
bank_arbiter.sv
amo_shim.sv
sram_bank.sv
amo_mem_top.sv
amo_mem_checker.sv
tb_amo_mem.sv

//--- Bender.yml
package:
  name: amo_mem

sources:
  - include_dirs:
      - .
    files:
      - amo_mem_bus_pkg.sv
      - amo_mem_op_pkg.sv
      - bank_arbiter.sv
      - amo_shim.sv
      - sram_bank.sv
      - amo_mem_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - amo_mem_checker.sv
      - tb_amo_mem.sv
